// ==== common/cordic_config.svh ====
`ifndef CORDIC_CONFIG_SVH
`define CORDIC_CONFIG_SVH

// Sample and angle format
`define CORDIC_WIDTH 14
`define CORDIC_FRAC 10

// Micro-rotation stages, shift index 0 .. ITERS-1
`define CORDIC_ITERS 12

// 1/K with 10 fraction bits
`define CORDIC_GAIN 622

// Angle constants, 1 rad = 1024
`define CORDIC_PI 3216
`define CORDIC_ZLIM 1785 // about 1.7433 rad

// Sideband
`define CORDIC_TAG_W 8

`endif

// ==== common/cordic_ctl_pkg.sv ====
`include "cordic_config.svh"

package cordic_ctl_pkg;

    typedef enum logic {
        MODE_ROTATE = 1'b0, // Rotate (x, y) by z
        MODE_VECTOR = 1'b1  // Rotate (x, y) onto x axis, angle in z
    } op_mode_e;

    // Per-item sideband, travels beside the data
    typedef struct packed {
        logic                     valid;
        op_mode_e                 mode;
        logic [`CORDIC_TAG_W-1:0] tag;
    } side_t;

endpackage

// ==== common/cordic_pkg.sv ====
`include "cordic_config.svh"

package cordic_pkg;

    // Two's complement sample, also used for angles
    typedef logic signed [`CORDIC_WIDTH-1:0] sample_t;

    typedef struct packed {
        sample_t x;
        sample_t y;
        sample_t z; // Angle accumulator
    } vec_t;

    // arctan(2^-i) scaled by 2^FRAC
    function automatic sample_t atan_lut(input int unsigned idx);
        sample_t a;
        case (idx)
            0:       a = 14'sd804;
            1:       a = 14'sd475;
            2:       a = 14'sd251;
            3:       a = 14'sd127;
            4:       a = 14'sd64;
            5:       a = 14'sd32;
            6:       a = 14'sd16;
            7:       a = 14'sd8;
            8:       a = 14'sd4;
            9:       a = 14'sd2;
            10:      a = 14'sd1;
            default: a = 14'sd0; // Below one LSB from here on
        endcase
        return a;
    endfunction

endpackage

// ==== cordic/cordic_gain.sv ====
`timescale 1ns/1ps
`include "cordic_config.svh"

module cordic_gain (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cordic_ctl_pkg::side_t side_i,
    input  cordic_pkg::vec_t      vec_i,
    output cordic_ctl_pkg::side_t side_o,
    output cordic_pkg::vec_t      vec_o
);

    localparam int PROD_W = `CORDIC_WIDTH + `CORDIC_FRAC;

    // 1/1.647 in Q0.10, one extra bit keeps it positive
    localparam logic signed [`CORDIC_FRAC:0] GAIN = (`CORDIC_FRAC + 1)'(`CORDIC_GAIN);

    logic signed [PROD_W-1:0] x_prod;
    logic signed [PROD_W-1:0] y_prod;
    cordic_pkg::vec_t         vec_q;
    logic                     valid_q;
    cordic_ctl_pkg::op_mode_e mode_q;
    logic [`CORDIC_TAG_W-1:0] tag_q;

    assign x_prod = vec_i.x * GAIN;
    assign y_prod = vec_i.y * GAIN;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= side_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        mode_q  <= side_i.mode;
        tag_q   <= side_i.tag;
        // Drop the fraction bits, floor rounding
        vec_q.x <= x_prod[PROD_W-1:`CORDIC_FRAC];
        vec_q.y <= y_prod[PROD_W-1:`CORDIC_FRAC];
        vec_q.z <= vec_i.z; // Angle is not scaled
    end

    assign side_o.valid = valid_q;
    assign side_o.mode  = mode_q;
    assign side_o.tag   = tag_q;
    assign vec_o        = vec_q;

endmodule

// ==== cordic/cordic_iter_stage.sv ====
`timescale 1ns/1ps
`include "cordic_config.svh"

module cordic_iter_stage #(
    parameter int STAGE = 0 // Shift index, 0 .. `CORDIC_ITERS-1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cordic_ctl_pkg::side_t side_i,
    input  cordic_pkg::vec_t      vec_i,
    output cordic_ctl_pkg::side_t side_o,
    output cordic_pkg::vec_t      vec_o
);

    localparam cordic_pkg::sample_t ATAN = cordic_pkg::atan_lut(STAGE);

    cordic_pkg::sample_t      x_sh;
    cordic_pkg::sample_t      y_sh;
    logic                     is_vec;
    logic                     hold;
    logic                     dir_pos;
    cordic_pkg::vec_t         vec_n;
    cordic_pkg::vec_t         vec_q;
    logic                     valid_q;
    cordic_ctl_pkg::op_mode_e mode_q;
    logic [`CORDIC_TAG_W-1:0] tag_q;

    assign is_vec = (side_i.mode == cordic_ctl_pkg::MODE_VECTOR);

    // Already converged, leave the item alone
    assign hold    = is_vec ? (vec_i.y == 0) : (vec_i.z == 0);
    assign dir_pos = is_vec ? (vec_i.y > 0) : (vec_i.z < 0);

    // Fixed shift per stage, both from the old x and y
    assign x_sh = vec_i.x >>> STAGE;
    assign y_sh = vec_i.y >>> STAGE;

    always_comb begin
        vec_n = vec_i;
        if (!hold) begin
            vec_n.x = dir_pos ? vec_i.x + y_sh : vec_i.x - y_sh;
            vec_n.y = dir_pos ? vec_i.y - x_sh : vec_i.y + x_sh;
            vec_n.z = dir_pos ? vec_i.z + ATAN : vec_i.z - ATAN;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= side_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        mode_q <= side_i.mode;
        tag_q  <= side_i.tag;
        vec_q  <= vec_n;
    end

    assign side_o.valid = valid_q;
    assign side_o.mode  = mode_q;
    assign side_o.tag   = tag_q;
    assign vec_o        = vec_q;

endmodule

// ==== cordic/cordic_prerotate.sv ====
`timescale 1ns/1ps
`include "cordic_config.svh"

module cordic_prerotate (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cordic_ctl_pkg::side_t side_i,
    input  cordic_pkg::vec_t      vec_i,
    output cordic_ctl_pkg::side_t side_o,
    output cordic_pkg::vec_t      vec_o
);

    localparam cordic_pkg::sample_t PI_POS = cordic_pkg::sample_t'(`CORDIC_PI);
    localparam cordic_pkg::sample_t PI_NEG = cordic_pkg::sample_t'(-`CORDIC_PI - 1);
    localparam cordic_pkg::sample_t Z_HI   = cordic_pkg::sample_t'(`CORDIC_ZLIM);
    localparam cordic_pkg::sample_t Z_LO   = cordic_pkg::sample_t'(-`CORDIC_ZLIM - 1);

    cordic_pkg::vec_t         vec_n;
    cordic_pkg::vec_t         vec_q;
    logic                     valid_q;
    cordic_ctl_pkg::op_mode_e mode_q;
    logic [`CORDIC_TAG_W-1:0] tag_q;

    always_comb begin
        vec_n = vec_i;
        if (side_i.mode == cordic_ctl_pkg::MODE_VECTOR) begin
            // Left half plane folds by pi, input z is don't care
            if (vec_i.x < 0) begin
                vec_n.x = -vec_i.x;
                vec_n.y = -vec_i.y;
                vec_n.z = (vec_i.y < 0) ? PI_NEG : PI_POS;
            end else begin
                vec_n.z = '0;
            end
        end else begin
            if (vec_i.z < Z_LO) begin
                vec_n.x = -vec_i.x;
                vec_n.y = -vec_i.y;
                vec_n.z = vec_i.z + PI_POS;
            end else if (vec_i.z > Z_HI) begin
                vec_n.x = -vec_i.x;
                vec_n.y = -vec_i.y;
                vec_n.z = vec_i.z - PI_POS;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= side_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        mode_q <= side_i.mode;
        tag_q  <= side_i.tag;
        vec_q  <= vec_n;
    end

    assign side_o.valid = valid_q;
    assign side_o.mode  = mode_q;
    assign side_o.tag   = tag_q;
    assign vec_o        = vec_q;

endmodule

// ==== source/cordic_top.sv ====
`timescale 1ns/1ps
`include "cordic_config.svh"

module cordic_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cordic_ctl_pkg::side_t in_side_i,
    input  cordic_pkg::vec_t      in_vec_i,
    output cordic_ctl_pkg::side_t out_side_o,
    output cordic_pkg::vec_t      out_vec_o
);

    // Index k is the input of micro-rotation stage k
    cordic_ctl_pkg::side_t side_s [0:`CORDIC_ITERS];
    cordic_pkg::vec_t      vec_s  [0:`CORDIC_ITERS];

    // Quadrant fold / angle wrap
    cordic_prerotate u_prerotate (
        .clk    (clk),
        .rst_n  (rst_n),
        .side_i (in_side_i),
        .vec_i  (in_vec_i),
        .side_o (side_s[0]),
        .vec_o  (vec_s[0])
    );

    for (genvar g = 0; g < `CORDIC_ITERS; g++) begin : g_iter
        cordic_iter_stage #(
            .STAGE (g)
        ) u_stage (
            .clk    (clk),
            .rst_n  (rst_n),
            .side_i (side_s[g]),
            .vec_i  (vec_s[g]),
            .side_o (side_s[g+1]),
            .vec_o  (vec_s[g+1])
        );
    end

    // Remove the CORDIC growth
    cordic_gain u_gain (
        .clk    (clk),
        .rst_n  (rst_n),
        .side_i (side_s[`CORDIC_ITERS]),
        .vec_i  (vec_s[`CORDIC_ITERS]),
        .side_o (out_side_o),
        .vec_o  (out_vec_o)
    );

endmodule

// ==== sources.f ====
+incdir+common
common/cordic_pkg.sv
common/cordic_ctl_pkg.sv
cordic/cordic_prerotate.sv
cordic/cordic_iter_stage.sv
cordic/cordic_gain.sv
source/cordic_top.sv
testbench/cordic_chk.sv
testbench/tb_cordic.sv

// ==== testbench/cordic_chk.sv ====
`timescale 1ns/1ps
`include "cordic_config.svh"

module cordic_chk (
    input logic                  clk,
    input logic                  rst_n,
    input cordic_ctl_pkg::side_t in_side_i,
    input cordic_ctl_pkg::side_t out_side_o,
    input cordic_pkg::vec_t      out_vec_o
);

    localparam int LATENCY = `CORDIC_ITERS + 2;

    int unsigned ticks = 0;
    logic        past_ok;

    // History must cover the full pipeline depth
    always @(posedge clk) begin
        if (ticks <= LATENCY)
            ticks <= ticks + 1;
    end

    assign past_ok = (ticks > LATENCY);

    a_valid_delay: assert property (
        @(posedge clk) disable iff (!rst_n || !past_ok)
        out_side_o.valid == $past(in_side_i.valid, LATENCY)
    ) else $error("Output valid does not match input valid from %0d cycles earlier", LATENCY);

    a_side_delay: assert property (
        @(posedge clk) disable iff (!rst_n || !past_ok)
        out_side_o.valid |->
            (out_side_o.tag == $past(in_side_i.tag, LATENCY)) &&
            (out_side_o.mode == $past(in_side_i.mode, LATENCY))
    ) else $error("Output tag or mode differs from the input %0d cycles earlier", LATENCY);

    // Vectoring folds into the right half plane
    a_vector_x: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_side_o.valid && out_side_o.mode == cordic_ctl_pkg::MODE_VECTOR) |->
            !out_vec_o.x[`CORDIC_WIDTH-1]
    ) else $error("Vectoring output has negative x");

endmodule

// ==== testbench/tb_cordic.sv ====
`timescale 1ns/1ps
`include "cordic_config.svh"

module tb_cordic;

    localparam int W             = `CORDIC_WIDTH;
    localparam int LATENCY       = `CORDIC_ITERS + 2;
    localparam int SEED          = 9;
    localparam int DIRECT_ITEMS  = 60;
    localparam int MIXED_ITEMS   = 200;
    localparam int DRAIN_TIMEOUT = 100;
    localparam int BURST_LIMIT   = 2000;

    logic                  clk;
    logic                  rst_n;
    cordic_ctl_pkg::side_t in_side;
    cordic_pkg::vec_t      in_vec;
    cordic_ctl_pkg::side_t out_side;
    cordic_pkg::vec_t      out_vec;

    logic [31:0]              lcg_state = SEED;
    int                       cycle = 0;
    logic [`CORDIC_TAG_W-1:0] tag_cnt = '0;

    // One scoreboard entry per accepted item
    cordic_ctl_pkg::side_t exp_side_q[$];
    cordic_pkg::vec_t      exp_vec_q[$];
    int                    exp_cycle_q[$];

    cordic_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_side_i  (in_side),
        .in_vec_i   (in_vec),
        .out_side_o (out_side),
        .out_vec_o  (out_vec)
    );

    bind cordic_top cordic_chk u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_side_i  (in_side_i),
        .out_side_o (out_side_o),
        .out_vec_o  (out_vec_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int unsigned span;
        logic [31:0] r;
        r    = lcg_next();
        span = hi - lo + 1;
        return lo + int'((r >> 8) % span); // Low LCG bits are weak
    endfunction

    // Two's complement wrap to the sample width
    function automatic int wrap_width(input int v);
        int m;
        m = v & ((1 << W) - 1);
        if (m >= (1 << (W - 1)))
            m = m - (1 << W);
        return m;
    endfunction

    function automatic int atan_step(input int i);
        int table_q [12] = '{804, 475, 251, 127, 64, 32, 16, 8, 4, 2, 1, 0};
        return (i < 12) ? table_q[i] : 0;
    endfunction

    function automatic cordic_pkg::vec_t model_item(input cordic_ctl_pkg::op_mode_e mode,
                                                   input cordic_pkg::vec_t v);
        int x;
        int y;
        int z;
        int xn;
        int yn;
        logic is_vec;
        logic pos;
        cordic_pkg::vec_t r;
        x      = wrap_width(int'(v.x));
        y      = wrap_width(int'(v.y));
        z      = wrap_width(int'(v.z));
        is_vec = (mode == cordic_ctl_pkg::MODE_VECTOR);
        if (is_vec) begin
            if (x < 0) begin
                z = (y < 0) ? -`CORDIC_PI - 1 : `CORDIC_PI;
                x = wrap_width(-x);
                y = wrap_width(-y);
            end else begin
                z = 0;
            end
        end else if (z < -`CORDIC_ZLIM - 1 || z > `CORDIC_ZLIM) begin
            z = wrap_width((z < 0) ? z + `CORDIC_PI : z - `CORDIC_PI);
            x = wrap_width(-x);
            y = wrap_width(-y);
        end
        for (int i = 0; i < `CORDIC_ITERS; i++) begin
            if (!(is_vec ? (y == 0) : (z == 0))) begin
                pos = is_vec ? (y > 0) : (z < 0);
                xn  = pos ? x + (y >>> i) : x - (y >>> i);
                yn  = pos ? y - (x >>> i) : y + (x >>> i);
                z   = wrap_width(pos ? z + atan_step(i) : z - atan_step(i));
                x   = wrap_width(xn);
                y   = wrap_width(yn);
            end
        end
        x   = wrap_width((x * `CORDIC_GAIN) >>> `CORDIC_FRAC); // Floor
        y   = wrap_width((y * `CORDIC_GAIN) >>> `CORDIC_FRAC);
        r.x = cordic_pkg::sample_t'(x);
        r.y = cordic_pkg::sample_t'(y);
        r.z = cordic_pkg::sample_t'(z);
        return r;
    endfunction

    task automatic halt_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
            halt_run();
        end
    endtask

    task automatic send_item(input logic valid, input cordic_ctl_pkg::op_mode_e mode,
                             input int x, input int y, input int z);
        cordic_ctl_pkg::side_t s;
        cordic_pkg::vec_t      v;
        s.valid = valid;
        s.mode  = mode;
        s.tag   = tag_cnt;
        v.x     = cordic_pkg::sample_t'(x);
        v.y     = cordic_pkg::sample_t'(y);
        v.z     = cordic_pkg::sample_t'(z);
        @(negedge clk);
        in_side = s;
        in_vec  = v;
        if (valid) begin
            exp_side_q.push_back(s);
            exp_vec_q.push_back(model_item(mode, v));
            exp_cycle_q.push_back(cycle); // Cycle in which the item is driven
            tag_cnt++;
        end
    endtask

    task automatic send_vector(input logic neg_x);
        int x;
        x = neg_x ? rand_range(-2047, -1) : rand_range(1, 2047);
        // Junk input z that vectoring must ignore
        send_item(1'b1, cordic_ctl_pkg::MODE_VECTOR, x, rand_range(-2047, 2047),
                  rand_range(-3216, 3216));
    endtask

    task automatic send_rotate(input int z);
        send_item(1'b1, cordic_ctl_pkg::MODE_ROTATE, rand_range(-2047, 2047),
                  rand_range(-2047, 2047), z);
    endtask

    always @(negedge clk) begin : monitor
        cordic_ctl_pkg::side_t es;
        cordic_pkg::vec_t      ev;
        int                    ec;
        if (rst_n && $isunknown(out_side.valid)) begin
            $display("Output valid is unknown after reset");
            halt_run();
        end
        if (rst_n && out_side.valid === 1'b1) begin
            if (exp_side_q.size() == 0) begin
                $display("Output valid seen with no item in flight");
                halt_run();
            end
            es = exp_side_q.pop_front();
            ev = exp_vec_q.pop_front();
            ec = exp_cycle_q.pop_front();
            check_value("out_side_o.tag", out_side.tag, es.tag);
            check_value("out_side_o.mode", out_side.mode, es.mode);
            check_value("out_vec_o.x", out_vec.x, ev.x);
            check_value("out_vec_o.y", out_vec.y, ev.y);
            check_value("out_vec_o.z", out_vec.z, ev.z);
            check_value("output latency", cycle - ec, LATENCY);
        end
    end

    initial begin : stimulus
        int waited;
        int sent;
        int guard;
        rst_n   = 1'b0;
        in_side = '0;
        in_vec  = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // Empty pipeline must stay quiet
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("out_side_o.valid", out_side.valid, 1'b0);
        end

        for (int i = 0; i < DIRECT_ITEMS; i++)
            send_vector(1'b0);
        for (int i = 0; i < DIRECT_ITEMS; i++)
            send_vector(1'b1);
        // Corner cases around the fold and both wrap limits
        send_item(1'b1, cordic_ctl_pkg::MODE_VECTOR, 0, 0, 0);
        send_item(1'b1, cordic_ctl_pkg::MODE_VECTOR, 0, -700, 0);
        send_item(1'b1, cordic_ctl_pkg::MODE_VECTOR, -900, 0, 0);
        send_rotate(3216);
        send_rotate(-3216);
        send_rotate(1785);
        send_rotate(1786);
        send_rotate(-1786);
        send_rotate(-1787);
        send_rotate(0);
        for (int i = 0; i < DIRECT_ITEMS; i++)
            send_rotate(rand_range(-3216, 3216));

        // Mixed burst with gaps
        sent  = 0;
        guard = 0;
        while (sent < MIXED_ITEMS && guard < BURST_LIMIT) begin
            guard++;
            if (rand_range(0, 1) == 0) begin
                send_item(1'b0, cordic_ctl_pkg::MODE_ROTATE, rand_range(-2047, 2047),
                          rand_range(-2047, 2047), rand_range(-3216, 3216));
            end else begin
                sent++;
                if (rand_range(0, 1) == 0)
                    send_vector(rand_range(0, 1) == 1);
                else
                    send_rotate(rand_range(-3216, 3216));
            end
        end
        send_item(1'b0, cordic_ctl_pkg::MODE_ROTATE, 0, 0, 0);

        waited = 0;
        while (exp_vec_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        for (int i = 0; i < LATENCY; i++)
            @(posedge clk); // Catch stray outputs

        if (exp_vec_q.size() == 0 && sent == MIXED_ITEMS) begin
            $display("All checks passed");
            $finish;
        end else begin
            if (sent != MIXED_ITEMS)
                $display("Only %0d of %0d burst items were sent", sent, MIXED_ITEMS);
            else
                $display("Timeout with %0d items still in the pipeline", exp_vec_q.size());
            halt_run();
        end
    end

endmodule
